// ==== source/ao_periph_pkg.sv ====
/* Widths, peripheral indices and the register map of the always-on subsystem.
   Registers are full 32-bit words, so every offset is word aligned. */
package ao_periph_pkg;

  localparam int unsigned DATA_W     = 32;
  localparam int unsigned OFFS_W     = 12;
  localparam int unsigned NUM_PERIPH = 4;
  localparam int unsigned SEL_W      = 2;

  localparam logic [SEL_W-1:0] SOC_CTRL_IDX  = 2'd0;
  localparam logic [SEL_W-1:0] FAST_INTR_IDX = 2'd1;
  localparam logic [SEL_W-1:0] GPIO_IDX      = 2'd2;
  localparam logic [SEL_W-1:0] TIMER_IDX     = 2'd3;

  // 4 KB per peripheral, 16 KB window
  localparam logic [DATA_W-1:0] AO_BASE = 32'h2000_0000;

  localparam int unsigned NUM_FAST_INTR = 15;
  localparam int unsigned NUM_GPIO      = 8;

  localparam logic [OFFS_W-1:0] SOC_EXIT_VALID_OFFS = 12'h000;
  localparam logic [OFFS_W-1:0] SOC_EXIT_VALUE_OFFS = 12'h004;
  localparam logic [OFFS_W-1:0] SOC_BOOT_SEL_OFFS   = 12'h008;

  localparam logic [OFFS_W-1:0] FI_PENDING_OFFS = 12'h000;
  localparam logic [OFFS_W-1:0] FI_ENABLE_OFFS  = 12'h004;

  localparam logic [OFFS_W-1:0] GPIO_OUT_OFFS         = 12'h000;
  localparam logic [OFFS_W-1:0] GPIO_OE_OFFS          = 12'h004;
  localparam logic [OFFS_W-1:0] GPIO_IN_OFFS          = 12'h008;
  localparam logic [OFFS_W-1:0] GPIO_INTR_EN_OFFS     = 12'h00C;
  localparam logic [OFFS_W-1:0] GPIO_INTR_STATUS_OFFS = 12'h010;

  localparam logic [OFFS_W-1:0] TIMER_CTRL_OFFS  = 12'h000;
  localparam logic [OFFS_W-1:0] TIMER_MTIME_OFFS = 12'h004;
  localparam logic [OFFS_W-1:0] TIMER_CMP0_OFFS  = 12'h008;
  localparam logic [OFFS_W-1:0] TIMER_CMP1_OFFS  = 12'h00C;

endpackage

// ==== source/obi_to_reg_bridge.sv ====
/* One transfer in flight at a time. The response follows two edges after the
   grant, and a write answers with zero read data. */
`timescale 1ns/1ps
module obi_to_reg_bridge (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  logic                            req_i,
  input  logic [ao_periph_pkg::DATA_W-1:0] addr_i,
  input  logic                            we_i,
  input  logic [ao_periph_pkg::DATA_W-1:0] wdata_i,
  output logic                            gnt_o,
  output logic                            rvalid_o,
  output logic [ao_periph_pkg::DATA_W-1:0] rdata_o,
  output logic                            reg_valid_o,
  output logic                            reg_write_o,
  output logic [ao_periph_pkg::DATA_W-1:0] reg_addr_o,
  output logic [ao_periph_pkg::DATA_W-1:0] reg_wdata_o,
  input  logic [ao_periph_pkg::DATA_W-1:0] reg_rdata_i
);

  typedef enum logic [1:0] {ST_IDLE, ST_ACCESS, ST_RESPOND} state_e;

  state_e                           state_q;
  logic                             we_q;
  logic [ao_periph_pkg::DATA_W-1:0] addr_q;
  logic [ao_periph_pkg::DATA_W-1:0] wdata_q;
  logic [ao_periph_pkg::DATA_W-1:0] rdata_q;

  assign gnt_o = req_i && (state_q == ST_IDLE);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        ST_IDLE:    if (gnt_o) state_q <= ST_ACCESS;
        ST_ACCESS:  state_q <= ST_RESPOND;
        default:    state_q <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (gnt_o) begin
      addr_q  <= addr_i;
      we_q    <= we_i;
      wdata_q <= wdata_i;
    end
    // Sampled at the end of the single access cycle
    if (state_q == ST_ACCESS) begin
      rdata_q <= we_q ? '0 : reg_rdata_i;
    end
  end

  assign reg_valid_o = (state_q == ST_ACCESS);
  assign reg_write_o = we_q;
  assign reg_addr_o  = addr_q;
  assign reg_wdata_o = wdata_q;
  assign rvalid_o    = (state_q == ST_RESPOND);
  assign rdata_o     = rdata_q;

endmodule

// ==== source/ao_reg_demux.sv ====
/* Steers one register access to a peripheral by address. Accesses outside
   the 16 KB window select nothing and read as zero. */
`timescale 1ns/1ps
module ao_reg_demux (
  input  logic                                reg_valid_i,
  input  logic                                reg_write_i,
  input  logic [ao_periph_pkg::DATA_W-1:0]     reg_addr_i,
  input  logic [ao_periph_pkg::DATA_W-1:0]     reg_wdata_i,
  output logic [ao_periph_pkg::DATA_W-1:0]     reg_rdata_o,
  output logic [ao_periph_pkg::NUM_PERIPH-1:0] sel_o,
  output logic                                write_o,
  output logic [ao_periph_pkg::OFFS_W-1:0]     offs_o,
  output logic [ao_periph_pkg::DATA_W-1:0]     wdata_o,
  input  logic [ao_periph_pkg::DATA_W-1:0]     rdata_soc_i,
  input  logic [ao_periph_pkg::DATA_W-1:0]     rdata_fi_i,
  input  logic [ao_periph_pkg::DATA_W-1:0]     rdata_gpio_i,
  input  logic [ao_periph_pkg::DATA_W-1:0]     rdata_timer_i
);

  // Lowest address bit above the peripheral index
  localparam int unsigned WIN_LSB = ao_periph_pkg::OFFS_W + ao_periph_pkg::SEL_W;

  logic                            in_window;
  logic [ao_periph_pkg::SEL_W-1:0] idx;

  assign in_window = reg_valid_i &&
      (reg_addr_i[ao_periph_pkg::DATA_W-1:WIN_LSB] ==
       ao_periph_pkg::AO_BASE[ao_periph_pkg::DATA_W-1:WIN_LSB]);
  assign idx = reg_addr_i[WIN_LSB-1:ao_periph_pkg::OFFS_W];

  always_comb begin
    sel_o = '0;
    if (in_window) begin
      sel_o[idx] = 1'b1;
    end
  end

  assign write_o = reg_write_i;
  assign offs_o  = reg_addr_i[ao_periph_pkg::OFFS_W-1:0];
  assign wdata_o = reg_wdata_i;

  always_comb begin
    reg_rdata_o = '0;
    if (in_window) begin
      case (idx)
        ao_periph_pkg::SOC_CTRL_IDX:  reg_rdata_o = rdata_soc_i;
        ao_periph_pkg::FAST_INTR_IDX: reg_rdata_o = rdata_fi_i;
        ao_periph_pkg::GPIO_IDX:      reg_rdata_o = rdata_gpio_i;
        ao_periph_pkg::TIMER_IDX:     reg_rdata_o = rdata_timer_i;
        default:                      reg_rdata_o = '0;
      endcase
    end
  end

endmodule

// ==== source/soc_ctrl.sv ====
/* Exit status registers and the boot select pin. Only bit 0 of EXIT_VALID
   is stored; unmapped offsets read as zero. */
`timescale 1ns/1ps
module soc_ctrl (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  logic                            sel_i,
  input  logic                            write_i,
  input  logic [ao_periph_pkg::OFFS_W-1:0] offs_i,
  input  logic [ao_periph_pkg::DATA_W-1:0] wdata_i,
  output logic [ao_periph_pkg::DATA_W-1:0] rdata_o,
  input  logic                            boot_select_i,
  output logic                            exit_valid_o,
  output logic [ao_periph_pkg::DATA_W-1:0] exit_value_o
);

  logic                             exit_valid_q;
  logic [ao_periph_pkg::DATA_W-1:0] exit_value_q;
  logic                             wr_en;

  assign wr_en = sel_i && write_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      exit_valid_q <= 1'b0;
      exit_value_q <= '0;
    end else if (wr_en) begin
      if (offs_i == ao_periph_pkg::SOC_EXIT_VALID_OFFS) begin
        exit_valid_q <= wdata_i[0];
      end
      if (offs_i == ao_periph_pkg::SOC_EXIT_VALUE_OFFS) begin
        exit_value_q <= wdata_i;
      end
    end
  end

  always_comb begin
    rdata_o = '0;
    case (offs_i)
      ao_periph_pkg::SOC_EXIT_VALID_OFFS: rdata_o[0] = exit_valid_q;
      ao_periph_pkg::SOC_EXIT_VALUE_OFFS: rdata_o    = exit_value_q;
      ao_periph_pkg::SOC_BOOT_SEL_OFFS:   rdata_o[0] = boot_select_i;
      default:                            rdata_o    = '0;
    endcase
  end

  assign exit_valid_o = exit_valid_q;
  assign exit_value_o = exit_value_q;

endmodule

// ==== source/fast_intr_ctrl.sv ====
/* Fast interrupt lines are sticky. A line still high when its pending bit
   is cleared sets it again in the same cycle. */
`timescale 1ns/1ps
module fast_intr_ctrl (
  input  logic                                   clk_i,
  input  logic                                   rst_n_i,
  input  logic                                   sel_i,
  input  logic                                   write_i,
  input  logic [ao_periph_pkg::OFFS_W-1:0]        offs_i,
  input  logic [ao_periph_pkg::DATA_W-1:0]        wdata_i,
  output logic [ao_periph_pkg::DATA_W-1:0]        rdata_o,
  input  logic [ao_periph_pkg::NUM_FAST_INTR-1:0] fast_intr_i,
  output logic [ao_periph_pkg::NUM_FAST_INTR-1:0] fast_intr_o
);

  logic [ao_periph_pkg::NUM_FAST_INTR-1:0] pending_q;
  logic [ao_periph_pkg::NUM_FAST_INTR-1:0] enable_q;
  logic [ao_periph_pkg::NUM_FAST_INTR-1:0] clr;

  assign clr = (sel_i && write_i && offs_i == ao_periph_pkg::FI_PENDING_OFFS) ?
               wdata_i[ao_periph_pkg::NUM_FAST_INTR-1:0] : '0;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pending_q <= '0;
      enable_q  <= '0;
    end else begin
      // Set beats clear
      pending_q <= (pending_q & ~clr) | fast_intr_i;
      if (sel_i && write_i && offs_i == ao_periph_pkg::FI_ENABLE_OFFS) begin
        enable_q <= wdata_i[ao_periph_pkg::NUM_FAST_INTR-1:0];
      end
    end
  end

  always_comb begin
    rdata_o = '0;
    case (offs_i)
      ao_periph_pkg::FI_PENDING_OFFS: rdata_o[ao_periph_pkg::NUM_FAST_INTR-1:0] = pending_q;
      ao_periph_pkg::FI_ENABLE_OFFS:  rdata_o[ao_periph_pkg::NUM_FAST_INTR-1:0] = enable_q;
      default:                        rdata_o = '0;
    endcase
  end

  assign fast_intr_o = pending_q & enable_q;

endmodule

// ==== source/gpio_ao.sv ====
/* Inputs pass a two-flop synchroniser, so GPIO_IN lags the pins by two
   cycles. Only rising edges raise status; write ones to clear. */
`timescale 1ns/1ps
module gpio_ao (
  input  logic                              clk_i,
  input  logic                              rst_n_i,
  input  logic                              sel_i,
  input  logic                              write_i,
  input  logic [ao_periph_pkg::OFFS_W-1:0]   offs_i,
  input  logic [ao_periph_pkg::DATA_W-1:0]   wdata_i,
  output logic [ao_periph_pkg::DATA_W-1:0]   rdata_o,
  input  logic [ao_periph_pkg::NUM_GPIO-1:0] gpio_i,
  output logic [ao_periph_pkg::NUM_GPIO-1:0] gpio_o,
  output logic [ao_periph_pkg::NUM_GPIO-1:0] gpio_en_o,
  output logic [ao_periph_pkg::NUM_GPIO-1:0] intr_gpio_o
);

  localparam int unsigned N = ao_periph_pkg::NUM_GPIO;

  logic [N-1:0] out_q, oe_q, intr_en_q, status_q;
  logic [N-1:0] sync1_q, sync2_q, prev_q;
  logic [N-1:0] wr_bits, clr;
  logic         wr_en;

  assign wr_en   = sel_i && write_i;
  assign wr_bits = wdata_i[N-1:0];
  assign clr     = (wr_en && offs_i == ao_periph_pkg::GPIO_INTR_STATUS_OFFS) ? wr_bits : '0;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      out_q     <= '0;
      oe_q      <= '0;
      intr_en_q <= '0;
      status_q  <= '0;
      sync1_q   <= '0;
      sync2_q   <= '0;
      prev_q    <= '0;
    end else begin
      sync1_q  <= gpio_i;
      sync2_q  <= sync1_q;
      prev_q   <= sync2_q;
      status_q <= (status_q & ~clr) | (sync2_q & ~prev_q);
      if (wr_en && offs_i == ao_periph_pkg::GPIO_OUT_OFFS) out_q <= wr_bits;
      if (wr_en && offs_i == ao_periph_pkg::GPIO_OE_OFFS) oe_q <= wr_bits;
      if (wr_en && offs_i == ao_periph_pkg::GPIO_INTR_EN_OFFS) intr_en_q <= wr_bits;
    end
  end

  always_comb begin
    rdata_o = '0;
    case (offs_i)
      ao_periph_pkg::GPIO_OUT_OFFS:         rdata_o[N-1:0] = out_q;
      ao_periph_pkg::GPIO_OE_OFFS:          rdata_o[N-1:0] = oe_q;
      ao_periph_pkg::GPIO_IN_OFFS:          rdata_o[N-1:0] = sync2_q;
      ao_periph_pkg::GPIO_INTR_EN_OFFS:     rdata_o[N-1:0] = intr_en_q;
      ao_periph_pkg::GPIO_INTR_STATUS_OFFS: rdata_o[N-1:0] = status_q;
      default:                              rdata_o = '0;
    endcase
  end

  assign gpio_o      = out_q;
  assign gpio_en_o   = oe_q;
  assign intr_gpio_o = status_q & intr_en_q;

endmodule

// ==== source/ao_timer.sv ====
/* 32-bit free-running MTIME with two level interrupts. MTIME wraps silently
   and compares are unsigned; both interrupts drop while disabled. */
`timescale 1ns/1ps
module ao_timer (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  logic                            sel_i,
  input  logic                            write_i,
  input  logic [ao_periph_pkg::OFFS_W-1:0] offs_i,
  input  logic [ao_periph_pkg::DATA_W-1:0] wdata_i,
  output logic [ao_periph_pkg::DATA_W-1:0] rdata_o,
  output logic                            timer_0_intr_o,
  output logic                            timer_1_intr_o
);

  logic                             enable_q;
  logic [ao_periph_pkg::DATA_W-1:0] mtime_q, cmp0_q, cmp1_q;
  logic                             intr0_q, intr1_q;
  logic                             wr_en;

  assign wr_en = sel_i && write_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      enable_q <= 1'b0;
      mtime_q  <= '0;
      cmp0_q   <= '1;
      cmp1_q   <= '1;
      intr0_q  <= 1'b0;
      intr1_q  <= 1'b0;
    end else begin
      // Register load wins over counting
      if (wr_en && offs_i == ao_periph_pkg::TIMER_MTIME_OFFS) begin
        mtime_q <= wdata_i;
      end else if (enable_q) begin
        mtime_q <= mtime_q + 1'b1;
      end
      if (wr_en && offs_i == ao_periph_pkg::TIMER_CTRL_OFFS) enable_q <= wdata_i[0];
      if (wr_en && offs_i == ao_periph_pkg::TIMER_CMP0_OFFS) cmp0_q <= wdata_i;
      if (wr_en && offs_i == ao_periph_pkg::TIMER_CMP1_OFFS) cmp1_q <= wdata_i;
      intr0_q <= enable_q && (mtime_q >= cmp0_q);
      intr1_q <= enable_q && (mtime_q >= cmp1_q);
    end
  end

  always_comb begin
    rdata_o = '0;
    case (offs_i)
      ao_periph_pkg::TIMER_CTRL_OFFS:  rdata_o[0] = enable_q;
      ao_periph_pkg::TIMER_MTIME_OFFS: rdata_o    = mtime_q;
      ao_periph_pkg::TIMER_CMP0_OFFS:  rdata_o    = cmp0_q;
      ao_periph_pkg::TIMER_CMP1_OFFS:  rdata_o    = cmp1_q;
      default:                         rdata_o    = '0;
    endcase
  end

  assign timer_0_intr_o = intr0_q;
  assign timer_1_intr_o = intr1_q;

endmodule

// ==== source/ao_peripheral_subsystem.sv ====
/* Always-on subsystem: bus bridge, address demux and four peripherals.
   Word accesses only; no byte enables and no bus error response. */
`timescale 1ns/1ps
module ao_peripheral_subsystem (
  input  logic                                   clk_i,
  input  logic                                   rst_n_i,
  input  logic                                   req_i,
  input  logic [ao_periph_pkg::DATA_W-1:0]        addr_i,
  input  logic                                   we_i,
  input  logic [ao_periph_pkg::DATA_W-1:0]        wdata_i,
  output logic                                   gnt_o,
  output logic                                   rvalid_o,
  output logic [ao_periph_pkg::DATA_W-1:0]        rdata_o,
  input  logic                                   boot_select_i,
  output logic                                   exit_valid_o,
  output logic [ao_periph_pkg::DATA_W-1:0]        exit_value_o,
  input  logic [ao_periph_pkg::NUM_FAST_INTR-1:0] fast_intr_i,
  output logic [ao_periph_pkg::NUM_FAST_INTR-1:0] fast_intr_o,
  input  logic [ao_periph_pkg::NUM_GPIO-1:0]      gpio_i,
  output logic [ao_periph_pkg::NUM_GPIO-1:0]      gpio_o,
  output logic [ao_periph_pkg::NUM_GPIO-1:0]      gpio_en_o,
  output logic [ao_periph_pkg::NUM_GPIO-1:0]      intr_gpio_o,
  output logic                                   timer_0_intr_o,
  output logic                                   timer_1_intr_o
);

  logic                                reg_valid, reg_write;
  logic [ao_periph_pkg::DATA_W-1:0]     reg_addr, reg_wdata, reg_rdata;
  logic [ao_periph_pkg::NUM_PERIPH-1:0] periph_sel;
  logic                                periph_write;
  logic [ao_periph_pkg::OFFS_W-1:0]     periph_offs;
  logic [ao_periph_pkg::DATA_W-1:0]     periph_wdata;
  logic [ao_periph_pkg::DATA_W-1:0]     rdata_soc, rdata_fi, rdata_gpio, rdata_timer;

  obi_to_reg_bridge bridge_i (
    .clk_i,
    .rst_n_i,
    .req_i,
    .addr_i,
    .we_i,
    .wdata_i,
    .gnt_o,
    .rvalid_o,
    .rdata_o,
    .reg_valid_o(reg_valid),
    .reg_write_o(reg_write),
    .reg_addr_o (reg_addr),
    .reg_wdata_o(reg_wdata),
    .reg_rdata_i(reg_rdata)
  );

  ao_reg_demux demux_i (
    .reg_valid_i  (reg_valid),
    .reg_write_i  (reg_write),
    .reg_addr_i   (reg_addr),
    .reg_wdata_i  (reg_wdata),
    .reg_rdata_o  (reg_rdata),
    .sel_o        (periph_sel),
    .write_o      (periph_write),
    .offs_o       (periph_offs),
    .wdata_o      (periph_wdata),
    .rdata_soc_i  (rdata_soc),
    .rdata_fi_i   (rdata_fi),
    .rdata_gpio_i (rdata_gpio),
    .rdata_timer_i(rdata_timer)
  );

  soc_ctrl soc_ctrl_i (
    .clk_i,
    .rst_n_i,
    .sel_i  (periph_sel[ao_periph_pkg::SOC_CTRL_IDX]),
    .write_i(periph_write),
    .offs_i (periph_offs),
    .wdata_i(periph_wdata),
    .rdata_o(rdata_soc),
    .boot_select_i,
    .exit_valid_o,
    .exit_value_o
  );

  fast_intr_ctrl fast_intr_ctrl_i (
    .clk_i,
    .rst_n_i,
    .sel_i  (periph_sel[ao_periph_pkg::FAST_INTR_IDX]),
    .write_i(periph_write),
    .offs_i (periph_offs),
    .wdata_i(periph_wdata),
    .rdata_o(rdata_fi),
    .fast_intr_i,
    .fast_intr_o
  );

  gpio_ao gpio_ao_i (
    .clk_i,
    .rst_n_i,
    .sel_i  (periph_sel[ao_periph_pkg::GPIO_IDX]),
    .write_i(periph_write),
    .offs_i (periph_offs),
    .wdata_i(periph_wdata),
    .rdata_o(rdata_gpio),
    .gpio_i,
    .gpio_o,
    .gpio_en_o,
    .intr_gpio_o
  );

  ao_timer timer_i (
    .clk_i,
    .rst_n_i,
    .sel_i  (periph_sel[ao_periph_pkg::TIMER_IDX]),
    .write_i(periph_write),
    .offs_i (periph_offs),
    .wdata_i(periph_wdata),
    .rdata_o(rdata_timer),
    .timer_0_intr_o,
    .timer_1_intr_o
  );

endmodule

// ==== sim/tb_ao_peripheral_subsystem.sv ====
/* Directed testbench for the always-on subsystem. Inputs change on the
   falling edge and outputs are sampled there or 1 ns later. */
`timescale 1ns/1ps
module tb_ao_peripheral_subsystem;

  localparam int unsigned TIMEOUT = 200;

  logic        clk = 1'b0;
  logic        rst_n, req, we, boot_sel;
  logic [31:0] addr, wdata;
  logic [14:0] fast_intr_in;
  logic [7:0]  gpio_in;
  logic        gnt, rvalid, exit_valid, timer0_intr, timer1_intr;
  logic [31:0] rdata, exit_value;
  logic [14:0] fast_intr_out;
  logic [7:0]  gpio_out, gpio_en, intr_gpio;
  integer      seed = 40579;
  int          check_errors = 0;
  int          timeout_errors = 0;

  always #2 clk = ~clk;

  ao_peripheral_subsystem dut0 (
    .clk_i(clk), .rst_n_i(rst_n), .req_i(req), .addr_i(addr), .we_i(we),
    .wdata_i(wdata), .gnt_o(gnt), .rvalid_o(rvalid), .rdata_o(rdata),
    .boot_select_i(boot_sel), .exit_valid_o(exit_valid), .exit_value_o(exit_value),
    .fast_intr_i(fast_intr_in), .fast_intr_o(fast_intr_out), .gpio_i(gpio_in),
    .gpio_o(gpio_out), .gpio_en_o(gpio_en), .intr_gpio_o(intr_gpio),
    .timer_0_intr_o(timer0_intr), .timer_1_intr_o(timer1_intr)
  );

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                             input string msg);
    if (got !== exp) begin
      $display("FAIL %0t: %s, got %h, expected %h", $time, msg, got, exp);
      check_errors++;
    end
  endtask

  // Starts at a falling edge and returns at the falling edge of the response
  task automatic transfer(input logic write, input logic [31:0] address,
                          input logic [31:0] data, output logic [31:0] rsp);
    int waited;
    waited = 0;
    rsp = '0;
    req = 1'b1;
    we = write;
    addr = address;
    wdata = data;
    #1;
    while (!gnt && waited < TIMEOUT) begin
      @(negedge clk);
      #1;
      waited++;
    end
    if (!gnt) begin
      $display("Timeout: the bus never granted the transfer to %h", address);
      timeout_errors++;
      req = 1'b0;
      @(negedge clk);
    end else begin
      @(posedge clk);
      @(negedge clk);
      check_value(32'(rvalid), 32'd0, "rvalid_o one edge after grant");
      check_value(32'(gnt), 32'd0, "gnt_o while access in flight");
      @(negedge clk);
      check_value(32'(rvalid), 32'd1, "rvalid_o two edges after grant");
      check_value(32'(gnt), 32'd0, "gnt_o during response");
      rsp = rdata;
      req = 1'b0;
    end
  endtask

  task automatic bus_write(input logic [31:0] address, input logic [31:0] data);
    logic [31:0] rsp;
    transfer(1'b1, address, data, rsp);
    check_value(rsp, 32'd0, "read data of a write");
  endtask

  task automatic bus_read(input logic [31:0] address, output logic [31:0] data);
    transfer(1'b0, address, 32'd0, data);
  endtask

  function automatic logic [31:0] reg_addr(input logic [1:0] idx, input logic [11:0] offs);
    reg_addr = ao_periph_pkg::AO_BASE | {18'd0, idx, offs};
  endfunction

  task automatic write_reg(input logic [1:0] idx, input logic [11:0] offs,
                           input logic [31:0] data);
    bus_write(reg_addr(idx, offs), data);
  endtask

  task automatic read_check(input logic [1:0] idx, input logic [11:0] offs,
                            input logic [31:0] exp, input string msg);
    logic [31:0] data;
    bus_read(reg_addr(idx, offs), data);
    check_value(data, exp, msg);
  endtask

  task automatic settle(input int cycles);
    repeat (cycles) @(negedge clk);
  endtask

  task automatic wait_timer_intr(input int which, input logic level);
    int   waited;
    logic seen;
    waited = 0;
    seen = (which == 0) ? timer0_intr : timer1_intr;
    while (seen !== level && waited < TIMEOUT) begin
      @(negedge clk);
      waited++;
      seen = (which == 0) ? timer0_intr : timer1_intr;
    end
    if (seen !== level) begin
      $display("Timeout: timer %0d interrupt never went to %0d", which, level);
      timeout_errors++;
    end
  endtask

  task automatic reset_values();
    logic [31:0] data;
    check_value(32'(gnt), 32'd0, "gnt_o idle without request");
    check_value(32'(rvalid), 32'd0, "rvalid_o after reset");
    check_value(32'(exit_valid), 32'd0, "exit_valid_o after reset");
    check_value({17'd0, fast_intr_out}, 32'd0, "fast_intr_o after reset");
    check_value({gpio_out, gpio_en, intr_gpio, 8'd0}, 32'd0, "gpio outputs after reset");
    check_value({30'd0, timer1_intr, timer0_intr}, 32'd0, "timer interrupts after reset");
    read_check(ao_periph_pkg::SOC_CTRL_IDX, ao_periph_pkg::SOC_EXIT_VALID_OFFS, 0, "exit valid");
    read_check(ao_periph_pkg::SOC_CTRL_IDX, ao_periph_pkg::SOC_EXIT_VALUE_OFFS, 0, "exit value");
    read_check(ao_periph_pkg::SOC_CTRL_IDX, ao_periph_pkg::SOC_BOOT_SEL_OFFS, 0, "boot sel");
    read_check(ao_periph_pkg::FAST_INTR_IDX, ao_periph_pkg::FI_PENDING_OFFS, 0, "fi pending");
    read_check(ao_periph_pkg::FAST_INTR_IDX, ao_periph_pkg::FI_ENABLE_OFFS, 0, "fi enable");
    read_check(ao_periph_pkg::GPIO_IDX, ao_periph_pkg::GPIO_OUT_OFFS, 0, "gpio out");
    read_check(ao_periph_pkg::GPIO_IDX, ao_periph_pkg::GPIO_OE_OFFS, 0, "gpio oe");
    read_check(ao_periph_pkg::GPIO_IDX, ao_periph_pkg::GPIO_IN_OFFS, 0, "gpio in");
    read_check(ao_periph_pkg::GPIO_IDX, ao_periph_pkg::GPIO_INTR_EN_OFFS, 0, "gpio intr en");
    read_check(ao_periph_pkg::GPIO_IDX, ao_periph_pkg::GPIO_INTR_STATUS_OFFS, 0, "gpio status");
    read_check(ao_periph_pkg::TIMER_IDX, ao_periph_pkg::TIMER_CTRL_OFFS, 0, "timer ctrl");
    read_check(ao_periph_pkg::TIMER_IDX, ao_periph_pkg::TIMER_MTIME_OFFS, 0, "mtime");
    read_check(ao_periph_pkg::TIMER_IDX, ao_periph_pkg::TIMER_CMP0_OFFS, '1, "cmp0");
    read_check(ao_periph_pkg::TIMER_IDX, ao_periph_pkg::TIMER_CMP1_OFFS, '1, "cmp1");
    // Just above and well below the 16 KB window
    bus_read(32'h2000_4000, data);
    check_value(data, 32'd0, "read above the window");
    bus_read(32'h1000_0004, data);
    check_value(data, 32'd0, "read below the window");
    bus_write(32'h2000_4004, 32'hdead_beef);
    bus_write(32'h3000_0004, 32'hcafe_f00d);
    read_check(ao_periph_pkg::SOC_CTRL_IDX, ao_periph_pkg::SOC_EXIT_VALUE_OFFS, 0, "stray write");
    check_value(exit_value, 32'd0, "exit_value_o after stray writes");
  endtask

  task automatic soc_ctrl_regs();
    logic [31:0] value;
    for (int i = 0; i < 4; i++) begin
      value = $random(seed);
      write_reg(ao_periph_pkg::SOC_CTRL_IDX, ao_periph_pkg::SOC_EXIT_VALUE_OFFS, value);
      read_check(ao_periph_pkg::SOC_CTRL_IDX, ao_periph_pkg::SOC_EXIT_VALUE_OFFS, value,
                 "exit value readback");
      check_value(exit_value, value, "exit_value_o");
    end
    write_reg(ao_periph_pkg::SOC_CTRL_IDX, ao_periph_pkg::SOC_EXIT_VALID_OFFS, 32'd1);
    check_value(32'(exit_valid), 32'd1, "exit_valid_o after write");
    read_check(ao_periph_pkg::SOC_CTRL_IDX, ao_periph_pkg::SOC_EXIT_VALID_OFFS, 1, "exit valid");
    boot_sel = 1'b1;
    read_check(ao_periph_pkg::SOC_CTRL_IDX, ao_periph_pkg::SOC_BOOT_SEL_OFFS, 1, "boot sel high");
    boot_sel = 1'b0;
    read_check(ao_periph_pkg::SOC_CTRL_IDX, ao_periph_pkg::SOC_BOOT_SEL_OFFS, 0, "boot sel low");
  endtask

  task automatic fast_intr_pending();
    logic [31:0] rnd;
    logic [14:0] enable, lines, clear;
    rnd = $random(seed);
    enable = rnd[14:0];
    rnd = $random(seed);
    lines = rnd[14:0] | 15'h1;
    rnd = $random(seed);
    clear = rnd[14:0];
    write_reg(ao_periph_pkg::FAST_INTR_IDX, ao_periph_pkg::FI_ENABLE_OFFS, {17'd0, enable});
    // One-cycle pulse on the chosen lines
    fast_intr_in = lines;
    @(negedge clk);
    fast_intr_in = '0;
    read_check(ao_periph_pkg::FAST_INTR_IDX, ao_periph_pkg::FI_PENDING_OFFS, {17'd0, lines},
               "pending after pulse");
    check_value({17'd0, fast_intr_out}, {17'd0, lines & enable}, "fast_intr_o after pulse");
    write_reg(ao_periph_pkg::FAST_INTR_IDX, ao_periph_pkg::FI_PENDING_OFFS, {17'd0, clear});
    read_check(ao_periph_pkg::FAST_INTR_IDX, ao_periph_pkg::FI_PENDING_OFFS,
               {17'd0, lines & ~clear}, "pending after partial clear");
    check_value({17'd0, fast_intr_out}, {17'd0, lines & ~clear & enable},
                "fast_intr_o after partial clear");
    write_reg(ao_periph_pkg::FAST_INTR_IDX, ao_periph_pkg::FI_PENDING_OFFS, 32'h7fff);
    read_check(ao_periph_pkg::FAST_INTR_IDX, ao_periph_pkg::FI_PENDING_OFFS, 0, "pending clear");
  endtask

  task automatic gpio_pins_and_intr();
    logic [31:0] rnd;
    logic [7:0]  enable, rising;
    rnd = $random(seed);
    write_reg(ao_periph_pkg::GPIO_IDX, ao_periph_pkg::GPIO_OUT_OFFS, {24'd0, rnd[7:0]});
    write_reg(ao_periph_pkg::GPIO_IDX, ao_periph_pkg::GPIO_OE_OFFS, {24'd0, rnd[15:8]});
    check_value({24'd0, gpio_out}, {24'd0, rnd[7:0]}, "gpio_o");
    check_value({24'd0, gpio_en}, {24'd0, rnd[15:8]}, "gpio_en_o");
    for (int i = 0; i < 3; i++) begin
      rnd = $random(seed);
      gpio_in = rnd[7:0];
      settle(3);
      read_check(ao_periph_pkg::GPIO_IDX, ao_periph_pkg::GPIO_IN_OFFS, {24'd0, rnd[7:0]},
                 "gpio in readback");
    end
    gpio_in = '0;
    settle(4);
    write_reg(ao_periph_pkg::GPIO_IDX, ao_periph_pkg::GPIO_INTR_STATUS_OFFS, 32'hff);
    read_check(ao_periph_pkg::GPIO_IDX, ao_periph_pkg::GPIO_INTR_STATUS_OFFS, 0, "status clear");
    rnd = $random(seed);
    enable = rnd[7:0];
    rising = rnd[15:8] | 8'h1;
    write_reg(ao_periph_pkg::GPIO_IDX, ao_periph_pkg::GPIO_INTR_EN_OFFS, {24'd0, enable});
    gpio_in = rising;
    settle(4);
    read_check(ao_periph_pkg::GPIO_IDX, ao_periph_pkg::GPIO_INTR_STATUS_OFFS, {24'd0, rising},
               "status after rising inputs");
    check_value({24'd0, intr_gpio}, {24'd0, rising & enable}, "intr_gpio_o");
    // Clear while the inputs are still high, so only a falling edge could set status
    write_reg(ao_periph_pkg::GPIO_IDX, ao_periph_pkg::GPIO_INTR_STATUS_OFFS, 32'hff);
    read_check(ao_periph_pkg::GPIO_IDX, ao_periph_pkg::GPIO_INTR_STATUS_OFFS, 0,
               "status clear with inputs high");
    gpio_in = '0;
    settle(4);
    read_check(ao_periph_pkg::GPIO_IDX, ao_periph_pkg::GPIO_INTR_STATUS_OFFS, 0,
               "status after falling inputs");
    check_value({24'd0, intr_gpio}, 32'd0, "intr_gpio_o after falling inputs");
  endtask

  task automatic timer_compares();
    logic [31:0] mtime;
    write_reg(ao_periph_pkg::TIMER_IDX, ao_periph_pkg::TIMER_CMP0_OFFS, 32'd20);
    write_reg(ao_periph_pkg::TIMER_IDX, ao_periph_pkg::TIMER_CMP1_OFFS, 32'd40);
    write_reg(ao_periph_pkg::TIMER_IDX, ao_periph_pkg::TIMER_MTIME_OFFS, 32'd0);
    write_reg(ao_periph_pkg::TIMER_IDX, ao_periph_pkg::TIMER_CTRL_OFFS, 32'd1);
    wait_timer_intr(0, 1'b1);
    check_value(32'(timer1_intr), 32'd0, "timer 1 before its compare");
    bus_read(reg_addr(ao_periph_pkg::TIMER_IDX, ao_periph_pkg::TIMER_MTIME_OFFS), mtime);
    check_value(32'(mtime >= 32'd20), 32'd1, "mtime at or past cmp0");
    wait_timer_intr(1, 1'b1);
    write_reg(ao_periph_pkg::TIMER_IDX, ao_periph_pkg::TIMER_CTRL_OFFS, 32'd0);
    wait_timer_intr(0, 1'b0);
    wait_timer_intr(1, 1'b0);
    read_check(ao_periph_pkg::TIMER_IDX, ao_periph_pkg::TIMER_CTRL_OFFS, 0, "timer disabled");
  endtask

  // Each call starts as the previous response ends, so req_i never drops
  task automatic back_to_back();
    logic [31:0] value;
    value = $random(seed);
    write_reg(ao_periph_pkg::SOC_CTRL_IDX, ao_periph_pkg::SOC_EXIT_VALUE_OFFS, value);
    read_check(ao_periph_pkg::SOC_CTRL_IDX, ao_periph_pkg::SOC_EXIT_VALUE_OFFS, value, "b2b exit");
    write_reg(ao_periph_pkg::GPIO_IDX, ao_periph_pkg::GPIO_OUT_OFFS, {24'd0, value[31:24]});
    read_check(ao_periph_pkg::GPIO_IDX, ao_periph_pkg::GPIO_OUT_OFFS, {24'd0, value[31:24]},
               "b2b gpio out");
    read_check(ao_periph_pkg::TIMER_IDX, ao_periph_pkg::TIMER_CMP1_OFFS, 32'd40, "b2b cmp1");
    read_check(ao_periph_pkg::SOC_CTRL_IDX, ao_periph_pkg::SOC_EXIT_VALID_OFFS, 1, "b2b valid");
  endtask

  initial begin
    rst_n = 1'b0;
    req = 1'b0;
    we = 1'b0;
    addr = '0;
    wdata = '0;
    boot_sel = 1'b0;
    fast_intr_in = '0;
    gpio_in = '0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    reset_values();
    soc_ctrl_regs();
    fast_intr_pending();
    gpio_pins_and_intr();
    timer_compares();
    back_to_back();
    $display("Errors: %0d value mismatches, %0d timeouts", check_errors, timeout_errors);
    if (check_errors == 0 && timeout_errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== ao_peripheral_subsystem.f ====
source/ao_periph_pkg.sv
source/obi_to_reg_bridge.sv
source/ao_reg_demux.sv
source/soc_ctrl.sv
source/fast_intr_ctrl.sv
source/gpio_ao.sv
source/ao_timer.sv
source/ao_peripheral_subsystem.sv
sim/tb_ao_peripheral_subsystem.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_ao_peripheral_subsystem
FILELIST  ?= ao_peripheral_subsystem.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= ALL CHECKS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
